// File: design/cmd_pairer.sv
`timescale 1ns/1ps

module cmd_pairer (
  input  logic                  sys_clk,
  input  logic                  reset_all_cmd_w,
  input  logic                  rx_valid_i,
  input  spi_bridge_pkg::byte_t rx_byte_i,
  output logic                  spi_start_o,
  output spi_bridge_pkg::byte_t spi_addr_o,
  output spi_bridge_pkg::byte_t spi_data_o
);
  import spi_bridge_pkg::*;

  // high once the address half of a pair is in
  logic have_addr_q;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      have_addr_q <= 1'b0;
      spi_start_o <= 1'b0;
    end else begin
      spi_start_o <= rx_valid_i && have_addr_q;
      if (rx_valid_i) begin
        have_addr_q <= ~have_addr_q;
      end
    end
  end

  // byte chain, old data slides into the address slot
  // addr and data stay put until the next byte
  always_ff @(posedge sys_clk) begin
    if (rx_valid_i) begin
      spi_addr_o <= spi_data_o;
      spi_data_o <= byte_t'(rx_byte_i);
    end
  end

endmodule

// File: design/panel_reset.sv
`timescale 1ns/1ps

module panel_reset (
  input  logic sys_clk,
  input  logic reset_all_cmd_w,
  output logic slm_reset_n_o
);
  import spi_bridge_pkg::*;

  hold_cnt_t hold_q;

  // reloads while the command is up, counts out after
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      hold_q <= hold_cnt_t'(panel_reset_hold);
    end else if (hold_q != '0) begin
      hold_q <= hold_q - 1'b1;
    end
  end

  // panel reset is active low
  assign slm_reset_n_o = !(reset_all_cmd_w || (hold_q != '0));

endmodule

// File: design/reply_queue.sv
`timescale 1ns/1ps

module reply_queue (
  input  logic                  sys_clk,
  input  logic                  reset_all_cmd_w,
  input  logic                  push_i,
  input  spi_bridge_pkg::byte_t push_byte_i,
  input  logic                  tx_busy_i,
  output logic                  tx_start_o,
  output spi_bridge_pkg::byte_t tx_byte_o
);
  import spi_bridge_pkg::*;

  byte_t  mem_q [queue_depth];
  q_ptr_t wr_ptr_q;
  q_ptr_t rd_ptr_q;
  q_cnt_t count_q;
  logic   push_ok;
  logic   pop_go;
  // set at pop, cleared once the transmitter reports busy
  logic   pending_q;

  // full queue drops the incoming reply
  assign push_ok = push_i && (count_q != q_cnt_t'(queue_depth));
  assign pop_go  = (count_q != '0) && !tx_busy_i && !pending_q;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      pending_q  <= 1'b0;
      tx_start_o <= 1'b0;
    end else begin
      // start trails the pop by one cycle
      tx_start_o <= pop_go;
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_go) begin
        rd_ptr_q  <= rd_ptr_q + 1'b1;
        pending_q <= 1'b1;
      end else if (tx_busy_i) begin
        pending_q <= 1'b0;
      end
      case ({push_ok, pop_go})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage and output byte
  always_ff @(posedge sys_clk) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= push_byte_i;
    end
    if (pop_go) begin
      tx_byte_o <= mem_q[rd_ptr_q];
    end
  end

endmodule

// File: design/spi_bridge_pkg.sv
package spi_bridge_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and timing
  ////////////////////////////////////////////////////////////////////////////

  // 50 MHz / 115200 baud
  localparam int clks_per_bit = 434;
  // sys clocks per half sck period
  localparam int spi_half_period = 4;
  localparam int spi_frame_bits = 16;
  localparam int queue_depth = 4;
  // 10 clocks at 50 MHz is 200 ns, twice the panel's minimum
  localparam int panel_reset_hold = 10;

  typedef logic [7:0] byte_t;
  // address in the upper byte, data in the lower
  typedef logic [15:0] spi_word_t;

  // counters sized from the constants above
  typedef logic [$clog2(clks_per_bit)-1:0] baud_cnt_t;
  typedef logic [2:0] uart_bit_t;
  typedef logic [$clog2(spi_half_period)-1:0] spi_div_t;
  typedef logic [$clog2(spi_frame_bits)-1:0] spi_bit_t;
  typedef logic [$clog2(queue_depth)-1:0] q_ptr_t;
  typedef logic [$clog2(queue_depth+1)-1:0] q_cnt_t;
  typedef logic [$clog2(panel_reset_hold+1)-1:0] hold_cnt_t;

  // terminal counts
  localparam baud_cnt_t baud_last = baud_cnt_t'(clks_per_bit - 1);
  localparam baud_cnt_t baud_mid = baud_cnt_t'(clks_per_bit / 2 - 1);
  localparam spi_div_t spi_div_last = spi_div_t'(spi_half_period - 1);
  localparam spi_bit_t spi_bit_last = spi_bit_t'(spi_frame_bits - 1);

  // state machines
  typedef enum logic [1:0] {uart_idle, uart_start, uart_data, uart_stop} uart_state_t;
  typedef enum logic [1:0] {spi_idle, spi_shift, spi_done} spi_state_t;

endpackage

// File: design/spi_bridge_top.sv
`timescale 1ns/1ps

module spi_bridge_top (
  input  logic sys_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  input  logic sout_i,
  output logic uart_tx_o,
  output logic sen_o,
  output logic sck_o,
  output logic sdat_o,
  output logic slm_reset_n_o
);

  ////////////////////////////////////////////////////////////////////////////
  // uart in, byte pairing
  ////////////////////////////////////////////////////////////////////////////

  logic                  rx_valid;
  spi_bridge_pkg::byte_t rx_byte;
  logic                  spi_start;
  spi_bridge_pkg::byte_t spi_addr;
  spi_bridge_pkg::byte_t spi_data;
  logic                  reply_valid;
  spi_bridge_pkg::byte_t reply_byte;
  logic                  tx_start;
  spi_bridge_pkg::byte_t tx_byte;
  logic                  tx_busy;

  uart_rx uart_rx_inst (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .serial_i        (uart_rx_i),
    .rx_valid_o      (rx_valid),
    .rx_byte_o       (rx_byte)
  );

  cmd_pairer cmd_pairer_inst (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_valid_i      (rx_valid),
    .rx_byte_i       (rx_byte),
    .spi_start_o     (spi_start),
    .spi_addr_o      (spi_addr),
    .spi_data_o      (spi_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // panel spi, reply path back to uart
  ////////////////////////////////////////////////////////////////////////////

  spi_master spi_master_inst (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .start_i         (spi_start),
    .addr_i          (spi_addr),
    .data_i          (spi_data),
    .sout_i          (sout_i),
    .sen_o           (sen_o),
    .sck_o           (sck_o),
    .sdat_o          (sdat_o),
    .reply_valid_o   (reply_valid),
    .reply_byte_o    (reply_byte)
  );

  reply_queue reply_queue_inst (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .push_i          (reply_valid),
    .push_byte_i     (reply_byte),
    .tx_busy_i       (tx_busy),
    .tx_start_o      (tx_start),
    .tx_byte_o       (tx_byte)
  );

  uart_tx uart_tx_inst (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .start_i         (tx_start),
    .byte_i          (tx_byte),
    .serial_o        (uart_tx_o),
    .busy_o          (tx_busy)
  );

  // panel reset stretcher
  panel_reset panel_reset_inst (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .slm_reset_n_o   (slm_reset_n_o)
  );

endmodule

// File: design/spi_master.sv
`timescale 1ns/1ps

module spi_master (
  input  logic                  sys_clk,
  input  logic                  reset_all_cmd_w,
  input  logic                  start_i,
  input  spi_bridge_pkg::byte_t addr_i,
  input  spi_bridge_pkg::byte_t data_i,
  input  logic                  sout_i,
  output logic                  sen_o,
  output logic                  sck_o,
  output logic                  sdat_o,
  output logic                  reply_valid_o,
  output spi_bridge_pkg::byte_t reply_byte_o
);
  import spi_bridge_pkg::*;

  spi_state_t state_q;
  spi_div_t   div_q;
  spi_bit_t   bit_q;
  spi_word_t  tx_sr_q;
  byte_t      rx_sr_q;
  logic       edge_now;

  // half period elapsed, sck toggles this cycle
  assign edge_now = (state_q == spi_shift) && (div_q == spi_div_last);
  // mosi is the msb of the frame register
  assign sdat_o = tx_sr_q[spi_frame_bits-1];

  //////////////////////////////////////////////////////////////////////////
  // frame sequencing
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state_q       <= spi_idle;
      div_q         <= '0;
      bit_q         <= '0;
      tx_sr_q       <= '0;
      sen_o         <= 1'b1;
      sck_o         <= 1'b0;
      reply_valid_o <= 1'b0;
    end else begin
      reply_valid_o <= 1'b0;
      case (state_q)
        spi_idle: begin
          // start outside idle is dropped
          if (start_i) begin
            tx_sr_q <= {addr_i, data_i};
            sen_o   <= 1'b0;
            div_q   <= '0;
            bit_q   <= '0;
            state_q <= spi_shift;
          end
        end
        spi_shift: begin
          if (edge_now) begin
            div_q <= '0;
            sck_o <= ~sck_o;
            // falling edge, move mosi to the next bit
            if (sck_o) begin
              tx_sr_q <= tx_sr_q << 1;
              bit_q   <= bit_q + 1'b1;
              if (bit_q == spi_bit_last) begin
                state_q <= spi_done;
              end
            end
          end else begin
            div_q <= div_q + 1'b1;
          end
        end
        spi_done: begin
          // cs release and reply strobe together
          sen_o         <= 1'b1;
          reply_valid_o <= 1'b1;
          state_q       <= spi_idle;
        end
        default: state_q <= spi_idle;
      endcase
    end
  end

  // miso sampled on rising sck, last eight bits kept
  always_ff @(posedge sys_clk) begin
    if (edge_now && !sck_o) begin
      rx_sr_q <= {rx_sr_q[6:0], sout_i};
    end
    if (state_q == spi_done) begin
      reply_byte_o <= rx_sr_q;
    end
  end

endmodule

// File: design/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
  input  logic                  sys_clk,
  input  logic                  reset_all_cmd_w,
  input  logic                  serial_i,
  output logic                  rx_valid_o,
  output spi_bridge_pkg::byte_t rx_byte_o
);
  import spi_bridge_pkg::*;

  uart_state_t state_q;
  baud_cnt_t   cnt_q;
  uart_bit_t   bit_q;
  logic [1:0]  sync_q;
  logic        rx_s;
  byte_t       shift_q;
  logic        sample_bit;

  // two flops against metastability, line idles high
  assign rx_s = sync_q[1];
  // middle of a data bit
  assign sample_bit = (state_q == uart_data) && (cnt_q == baud_last);

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state_q    <= uart_idle;
      cnt_q      <= '0;
      bit_q      <= '0;
      sync_q     <= 2'b11;
      rx_valid_o <= 1'b0;
    end else begin
      sync_q     <= {sync_q[0], serial_i};
      rx_valid_o <= 1'b0;
      case (state_q)
        uart_idle: begin
          cnt_q <= '0;
          bit_q <= '0;
          if (!rx_s) begin
            state_q <= uart_start;
          end
        end
        uart_start: begin
          // half a bit in, still low or it was a glitch
          if (cnt_q == baud_mid) begin
            cnt_q   <= '0;
            state_q <= rx_s ? uart_idle : uart_data;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        uart_data: begin
          if (cnt_q == baud_last) begin
            cnt_q <= '0;
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) begin
              state_q <= uart_stop;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        uart_stop: begin
          // low stop bit, framing error, byte dropped
          if (cnt_q == baud_last) begin
            state_q    <= uart_idle;
            rx_valid_o <= rx_s;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= uart_idle;
      endcase
    end
  end

  // lsb arrives first, shift in from the top
  always_ff @(posedge sys_clk) begin
    if (sample_bit) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
    if (state_q == uart_stop && cnt_q == baud_last) begin
      rx_byte_o <= shift_q;
    end
  end

endmodule

// File: design/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
  input  logic                  sys_clk,
  input  logic                  reset_all_cmd_w,
  input  logic                  start_i,
  input  spi_bridge_pkg::byte_t byte_i,
  output logic                  serial_o,
  output logic                  busy_o
);
  import spi_bridge_pkg::*;

  uart_state_t state_q;
  baud_cnt_t   cnt_q;
  uart_bit_t   bit_q;
  byte_t       shift_q;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state_q  <= uart_idle;
      cnt_q    <= '0;
      bit_q    <= '0;
      serial_o <= 1'b1;
      busy_o   <= 1'b0;
    end else begin
      case (state_q)
        uart_idle: begin
          serial_o <= 1'b1;
          busy_o   <= 1'b0;
          cnt_q    <= '0;
          bit_q    <= '0;
          if (start_i) begin
            // start bit goes out right away
            shift_q  <= byte_i;
            serial_o <= 1'b0;
            busy_o   <= 1'b1;
            state_q  <= uart_start;
          end
        end
        uart_start: begin
          if (cnt_q == baud_last) begin
            cnt_q    <= '0;
            serial_o <= shift_q[0];
            state_q  <= uart_data;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        uart_data: begin
          if (cnt_q == baud_last) begin
            cnt_q   <= '0;
            bit_q   <= bit_q + 1'b1;
            shift_q <= shift_q >> 1;
            if (bit_q == 3'd7) begin
              serial_o <= 1'b1;
              state_q  <= uart_stop;
            end else begin
              // lsb first, next bit sits at index 1
              serial_o <= shift_q[1];
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        uart_stop: begin
          // busy drops once the full stop bit is on the line
          if (cnt_q == baud_last) begin
            busy_o  <= 1'b0;
            state_q <= uart_idle;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= uart_idle;
      endcase
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# build and run the bridge testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module spi_bridge_tb -f sim.f -o spi_bridge_sim

# the simulator exits nonzero on a fatal error, the log decides
./obj_dir/spi_bridge_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
  exit 1
fi
if ! grep -q "Everything OK" sim.log; then
  exit 1
fi
exit 0

// File: sim.f
design/spi_bridge_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/cmd_pairer.sv
design/spi_master.sv
design/reply_queue.sv
design/panel_reset.sv
design/spi_bridge_top.sv
tb/spi_bridge_chk.sv
tb/spi_bridge_tb.sv

// File: tb/spi_bridge_chk.sv
`timescale 1ns/1ps

module spi_bridge_chk (
  input logic sys_clk,
  input logic reset_all_cmd_w,
  input logic sen_i,
  input logic sck_i,
  input logic reply_valid_i
);

  // sck parks low whenever chip select is released
  sck_idle_low: assert property (@(posedge sys_clk) disable iff (reset_all_cmd_w)
    sen_i |-> !sck_i)
    else $error("sck_o high while sen_o is high");

  // reply strobe is a single cycle
  reply_one_cycle: assert property (@(posedge sys_clk) disable iff (reset_all_cmd_w)
    reply_valid_i |=> !reply_valid_i)
    else $error("reply_valid_o held longer than one cycle");

  // chip select stays released after the frame
  sen_after_reply: assert property (@(posedge sys_clk) disable iff (reset_all_cmd_w)
    reply_valid_i |=> sen_i)
    else $error("sen_o low in the cycle after reply_valid_o");

endmodule

bind spi_master spi_bridge_chk spi_bridge_chk_inst (
  .sys_clk         (sys_clk),
  .reset_all_cmd_w (reset_all_cmd_w),
  .sen_i           (sen_o),
  .sck_i           (sck_o),
  .reply_valid_i   (reply_valid_o)
);

// File: tb/spi_bridge_tb.sv
`timescale 1ns/1ps

module spi_bridge_tb;
  import spi_bridge_pkg::*;

  localparam int num_pairs = 20;
  localparam int num_tests = 5;
  // stray byte, the pair after the mid-pair reset, then the random pairs
  localparam int bytes_sent = 2 * num_pairs + 3;
  localparam int timeout_cycles = num_tests * bytes_sent * 12 * clks_per_bit + 50000;

  // dut inputs start idle, reset asserted
  logic sys_clk = 1'b0;
  logic reset_all_cmd_w = 1'b1;
  logic uart_rx_i = 1'b1;
  logic sout_i = 1'b0;
  logic uart_tx_o;
  logic sen_o;
  logic sck_o;
  logic sdat_o;
  logic slm_reset_n_o;

  int          cycle_cnt = 0;
  int          frames_checked = 0;
  int          replies_checked = 0;
  logic [31:0] rng_q = 32'd8435;
  spi_word_t   exp_frames[$];
  spi_word_t   got_frames[$];
  byte_t       exp_replies[$];
  byte_t       got_replies[$];

  // panel model state
  logic      sck_prev_q = 1'b0;
  int        slave_bit_q = 0;
  spi_word_t mosi_q = '0;
  byte_t     miso_q = '0;

  spi_bridge_top spi_bridge_top_inst (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_i),
    .sout_i          (sout_i),
    .uart_tx_o       (uart_tx_o),
    .sen_o           (sen_o),
    .sck_o           (sck_o),
    .sdat_o          (sdat_o),
    .slm_reset_n_o   (slm_reset_n_o)
  );

  // 4 ns period
  initial begin
    forever #2 sys_clk = ~sys_clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model and helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // panel answers with the inverted address byte
  function automatic byte_t expected_reply(input byte_t addr);
    return ~addr;
  endfunction

  task automatic report_fail();
    $display("Something failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %b actual %b", name, expected, actual);
      report_fail();
    end
  endtask

  task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %02h actual %02h", name, expected, actual);
      report_fail();
    end
  endtask

  task automatic check_word(input string name, input spi_word_t expected,
                            input spi_word_t actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %04h actual %04h", name, expected, actual);
      report_fail();
    end
  endtask

  task automatic check_cycles(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
      report_fail();
    end
  endtask

  task automatic draw_byte(output byte_t value);
    rng_q = xorshift32(rng_q);
    value = rng_q[7:0];
  endtask

  // called right after a rising edge, returns on one
  task automatic send_byte(input byte_t value);
    uart_rx_i <= 1'b0;
    repeat (clks_per_bit) @(posedge sys_clk);
    // lsb first
    for (int i = 0; i < 8; i++) begin
      uart_rx_i <= value[i];
      repeat (clks_per_bit) @(posedge sys_clk);
    end
    uart_rx_i <= 1'b1;
    repeat (clks_per_bit) @(posedge sys_clk);
  endtask

  // expectations go in before the bytes leave
  task automatic send_pair(input byte_t addr, input byte_t data);
    exp_frames.push_back({addr, data});
    exp_replies.push_back(expected_reply(addr));
    send_byte(addr);
    send_byte(data);
  endtask

  task automatic wait_for_checks(input int count);
    while (frames_checked < count || replies_checked < count) begin
      @(posedge sys_clk);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // panel spi slave model
  ////////////////////////////////////////////////////////////////////////////

  // rising sck seen one clock late, mosi only moves on falling sck
  always @(posedge sys_clk) begin : spi_slave
    spi_word_t cap;
    cap = {mosi_q[14:0], sdat_o};
    sck_prev_q <= sck_o;
    if (reset_all_cmd_w || sen_o) begin
      slave_bit_q <= 0;
      sout_i      <= 1'b0;
    end else if (sck_o && !sck_prev_q) begin
      mosi_q      <= cap;
      slave_bit_q <= slave_bit_q + 1;
      if (slave_bit_q == 7) begin
        // address complete, miso for bit 8 onward
        sout_i <= ~cap[7];
        miso_q <= {~cap[6:0], 1'b0};
      end else if (slave_bit_q >= 8 && slave_bit_q <= 14) begin
        sout_i <= miso_q[7];
        miso_q <= miso_q << 1;
      end else if (slave_bit_q == 15) begin
        got_frames.push_back(cap);
        sout_i <= 1'b0;
      end
    end
  end

  // uart monitor on the reply line
  initial begin : uart_monitor
    byte_t rx_b;
    forever begin
      @(posedge sys_clk);
      if (!reset_all_cmd_w && uart_tx_o === 1'b0) begin
        // to mid start bit, then one bit period per sample
        repeat (clks_per_bit / 2) @(posedge sys_clk);
        for (int i = 0; i < 8; i++) begin
          repeat (clks_per_bit) @(posedge sys_clk);
          rx_b[i] = uart_tx_o;
        end
        repeat (clks_per_bit) @(posedge sys_clk);
        if (uart_tx_o !== 1'b1) begin
          $display("ERROR: reply byte %02h ended with a low stop bit", rx_b);
          report_fail();
        end else begin
          got_replies.push_back(rx_b);
        end
      end
    end
  end

  // compares in arrival order
  always @(posedge sys_clk) begin : compare_proc
    spi_word_t frame_exp;
    spi_word_t frame_got;
    byte_t     reply_exp;
    byte_t     reply_got;
    if (got_frames.size() != 0) begin
      if (exp_frames.size() == 0) begin
        $display("ERROR: SPI frame %04h appeared with no pair sent", got_frames[0]);
        report_fail();
      end else begin
        frame_exp = exp_frames.pop_front();
        frame_got = got_frames.pop_front();
        check_word($sformatf("spi frame %0d", frames_checked), frame_exp, frame_got);
        frames_checked++;
      end
    end
    if (got_replies.size() != 0) begin
      if (exp_replies.size() == 0) begin
        $display("ERROR: UART reply %02h arrived with no frame sent", got_replies[0]);
        report_fail();
      end else begin
        reply_exp = exp_replies.pop_front();
        reply_got = got_replies.pop_front();
        check_byte($sformatf("uart reply %0d", replies_checked), reply_exp, reply_got);
        replies_checked++;
      end
    end
  end

  // hang guard
  always @(posedge sys_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == timeout_cycles) begin
      $display("ERROR: run hung, %0d cycles passed before all replies came back", cycle_cnt);
      report_fail();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main_seq
    byte_t addr;
    byte_t data;
    byte_t stray;
    int    hold_cycles;

    // idle outputs while reset is held
    repeat (5) @(posedge sys_clk);
    check_bit("reset uart_tx_o", 1'b1, uart_tx_o);
    check_bit("reset sen_o", 1'b1, sen_o);
    check_bit("reset sck_o", 1'b0, sck_o);
    check_bit("reset slm_reset_n_o", 1'b0, slm_reset_n_o);
    reset_all_cmd_w <= 1'b0;

    // count clocks until the panel leaves reset
    hold_cycles = 0;
    @(posedge sys_clk);
    while (!slm_reset_n_o && hold_cycles <= 4 * panel_reset_hold) begin
      hold_cycles++;
      @(posedge sys_clk);
    end
    check_cycles("panel reset hold", panel_reset_hold, hold_cycles);

    // lone byte, no frame during it or for twenty bit times after
    draw_byte(stray);
    fork
      send_byte(stray);
      repeat (30 * clks_per_bit) begin
        @(posedge sys_clk);
        check_bit("sen_o after single byte", 1'b1, sen_o);
      end
    join

    // stray byte is now a dangling address
    // reset drops it, next byte must be the address
    reset_all_cmd_w <= 1'b1;
    repeat (5) @(posedge sys_clk);
    reset_all_cmd_w <= 1'b0;
    @(posedge sys_clk);
    draw_byte(addr);
    draw_byte(data);
    send_pair(addr, data);
    wait_for_checks(1);

    // random pairs back to back
    for (int p = 0; p < num_pairs; p++) begin
      draw_byte(addr);
      draw_byte(data);
      send_pair(addr, data);
    end
    wait_for_checks(num_pairs + 1);

    // quiet time so an extra frame or reply would still be caught
    repeat (12 * clks_per_bit) @(posedge sys_clk);

    $display("Everything OK");
    $finish;
  end

endmodule
